// File: Makefile
# Verilator build for the AXI to peripheral bridge testbench

SIM      := verilator
TOP      := tb_axi2per
FILELIST := sim.f
OBJ_DIR  := obj_dir
FLAGS    := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) -f $(FILELIST)

# Exit status of the simulation is the result
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: axi2per/axi2per_req_channel.sv
`timescale 1ns/1ps

module axi2per_req_channel (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // AXI address and write data
  input  logic                   aw_valid_i,
  input  axi2per_pkg::axi_ax_t   aw_i,
  output logic                   aw_ready_o,
  input  logic                   w_valid_i,
  input  axi2per_pkg::axi_w_t    w_i,
  output logic                   w_ready_o,
  input  logic                   ar_valid_i,
  input  axi2per_pkg::axi_ax_t   ar_i,
  output logic                   ar_ready_o,

  // Peripheral request
  output logic                   per_req_o,
  output axi2per_pkg::per_req_t  per_req_data_o,
  input  logic                   per_gnt_i,

  // Context to the response channel
  output logic                   trans_req_o,
  output axi2per_pkg::trans_t    trans_o,
  input  logic                   trans_done_i
);

  // Idle: accept, Request: drive bus, Wait: response in progress
  typedef enum logic [1:0] {
    Idle,
    Request,
    Wait
  } state_e;

  state_e state_d, state_q;

  // Request payload and context, loaded on the AXI handshake
  axi2per_pkg::per_req_t req_d, req_q;
  axi2per_pkg::trans_t   trans_d, trans_q;
  logic                  load;

  // Write needs both AW and W present
  logic wr_pending;
  // Lane picked by address bit 2
  logic wr_lane;
  logic rd_lane;

  assign wr_pending = aw_valid_i & w_valid_i;
  assign wr_lane    = aw_i.addr[2];
  assign rd_lane    = ar_i.addr[2];

  // ****************************************
  // Acceptance and next state
  // ****************************************

  always_comb begin
    state_d    = state_q;
    aw_ready_o = 1'b0;
    w_ready_o  = 1'b0;
    ar_ready_o = 1'b0;
    load       = 1'b0;
    req_d      = req_q;
    trans_d    = trans_q;

    unique case (state_q)
      Idle: begin
        // Writes win over reads
        if (wr_pending) begin
          aw_ready_o    = 1'b1;
          w_ready_o     = 1'b1;
          load          = 1'b1;
          req_d.add     = aw_i.addr;
          req_d.wen     = 1'b0;
          // Upper or lower half of the AXI word
          req_d.wdata   = wr_lane ? w_i.data[63:32] : w_i.data[31:0];
          req_d.be      = wr_lane ? w_i.strb[7:4] : w_i.strb[3:0];
          trans_d.wen   = 1'b0;
          trans_d.id    = aw_i.id;
          trans_d.lane  = wr_lane;
          state_d       = Request;
        end else if (ar_valid_i) begin
          ar_ready_o    = 1'b1;
          load          = 1'b1;
          req_d.add     = ar_i.addr;
          req_d.wen     = 1'b1;
          // No write data on a read
          req_d.wdata   = '0;
          req_d.be      = '1;
          trans_d.wen   = 1'b1;
          trans_d.id    = ar_i.id;
          trans_d.lane  = rd_lane;
          state_d       = Request;
        end
      end

      Request: begin
        // Hold request until granted
        if (per_gnt_i) begin
          state_d = Wait;
        end
      end

      Wait: begin
        // Next transaction only after the R or B handshake
        if (trans_done_i) begin
          state_d = Idle;
        end
      end

      default: state_d = Idle;
    endcase
  end

  // ****************************************
  // Registers
  // ****************************************

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Payload
  always_ff @(posedge clk_i) begin
    if (load) begin
      req_q   <= req_d;
      trans_q <= trans_d;
    end
  end

  // Outputs
  assign per_req_o      = (state_q == Request);
  assign per_req_data_o = req_q;
  // Context goes out in the grant cycle
  assign trans_req_o    = per_req_o & per_gnt_i;
  assign trans_o        = trans_q;

  // ****************************************
  // Checks
  // ****************************************

  // Completion only comes back while waiting for it
  assert property (@(posedge clk_i) disable iff (!rst_ni)
      trans_done_i |-> state_q == Wait)
    else $error("Completion arrived outside Wait");

endmodule

// File: axi2per/axi2per_res_channel.sv
`timescale 1ns/1ps

module axi2per_res_channel (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // Peripheral response
  input  logic                   per_r_valid_i,
  input  axi2per_pkg::per_resp_t per_r_resp_i,

  // Context from the request channel
  input  logic                   trans_req_i,
  input  axi2per_pkg::trans_t    trans_i,

  // AXI read data
  output logic                   r_valid_o,
  output axi2per_pkg::axi_r_t    r_o,
  input  logic                   r_ready_i,

  // AXI write response
  output logic                   b_valid_o,
  output axi2per_pkg::axi_b_t    b_o,
  input  logic                   b_ready_i,

  // Completion back to the request channel
  output logic                   trans_done_o
);

  typedef enum logic {
    Idle,
    Pending
  } state_e;

  state_e state_d, state_q;

  // Latched context and answer
  axi2per_pkg::trans_t    trans_q;
  axi2per_pkg::per_resp_t resp_q;

  axi2per_pkg::axi_resp_t resp_code;
  axi2per_pkg::axi_data_t r_data;

  // ****************************************
  // Response shaping
  // ****************************************

  // Error flag maps to SLVERR
  assign resp_code = resp_q.opc ? axi2per_pkg::RESP_SLVERR : axi2per_pkg::RESP_OKAY;

  // Lane 0 fills the low half, lane 1 the high half
  always_comb begin
    if (trans_q.lane) begin
      r_data = {resp_q.rdata, axi2per_pkg::per_data_t'('0)};
    end else begin
      r_data = {axi2per_pkg::per_data_t'('0), resp_q.rdata};
    end
  end

  // Single beat, last always set
  assign r_o.id   = trans_q.id;
  assign r_o.data = r_data;
  assign r_o.resp = resp_code;
  assign r_o.last = 1'b1;

  assign b_o.id   = trans_q.id;
  assign b_o.resp = resp_code;

  // Valid held in Pending until the handshake
  // wen high selects the R channel
  assign r_valid_o = (state_q == Pending) & trans_q.wen;
  assign b_valid_o = (state_q == Pending) & ~trans_q.wen;

  assign trans_done_o = (r_valid_o & r_ready_i) | (b_valid_o & b_ready_i);

  // ****************************************
  // FSM
  // ****************************************

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      Idle: begin
        if (per_r_valid_i) begin
          state_d = Pending;
        end
      end
      Pending: begin
        if (trans_done_o) begin
          state_d = Idle;
        end
      end
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
    end else begin
      state_q <= state_d;
    end
  end

  // Context and answer capture
  always_ff @(posedge clk_i) begin
    if (trans_req_i) begin
      trans_q <= trans_i;
    end
    if (per_r_valid_i) begin
      resp_q <= per_r_resp_i;
    end
  end

  // ****************************************
  // Checks
  // ****************************************

  // Only one response outstanding at a time
  assert property (@(posedge clk_i) disable iff (!rst_ni)
      per_r_valid_i |-> state_q == Idle)
    else $error("Peripheral response arrived while busy");

  // Pending answer keeps its payload until the handshake
  assert property (@(posedge clk_i) disable iff (!rst_ni)
      state_q == Pending && !trans_done_o |=> $stable(r_o) && $stable(b_o))
    else $error("R or B payload changed before the handshake");

endmodule

// File: common/axi2per_pkg.sv
package axi2per_pkg;

  // ****************************************
  // Widths with a meaning
  // ****************************************

  // AXI side
  typedef logic [2:0]  axi_id_t;
  typedef logic [31:0] axi_addr_t;
  typedef logic [63:0] axi_data_t;
  typedef logic [7:0]  axi_strb_t;
  typedef logic [1:0]  axi_resp_t;

  // Peripheral side
  typedef logic [31:0] per_addr_t;
  typedef logic [31:0] per_data_t;
  typedef logic [3:0]  per_be_t;

  // ****************************************
  // Constants
  // ****************************************

  // AXI response codes
  localparam axi_resp_t RESP_OKAY   = 2'd0;
  localparam axi_resp_t RESP_SLVERR = 2'd2;

  // Peripheral memory, 32-bit words
  localparam int unsigned MEM_WORDS = 64;
  // Word index width, bits 7:2 of the byte address
  localparam int unsigned MEM_IDX_W = $clog2(MEM_WORDS);

  // ****************************************
  // Channel payloads
  // ****************************************

  // Address channel, same layout for AW and AR
  typedef struct packed {
    axi_id_t   id;
    axi_addr_t addr;
  } axi_ax_t;

  // Write data channel
  typedef struct packed {
    axi_data_t data;
    axi_strb_t strb;
  } axi_w_t;

  // Read data channel
  typedef struct packed {
    axi_id_t   id;
    axi_data_t data;
    axi_resp_t resp;
    logic      last;
  } axi_r_t;

  // Write response channel
  typedef struct packed {
    axi_id_t   id;
    axi_resp_t resp;
  } axi_b_t;

  // Peripheral request, wen high means read
  typedef struct packed {
    per_addr_t add;
    logic      wen;
    per_data_t wdata;
    per_be_t   be;
  } per_req_t;

  // Peripheral response, opc high flags an error
  typedef struct packed {
    logic      opc;
    per_data_t rdata;
  } per_resp_t;

  // Context handed from request to response channel
  typedef struct packed {
    logic    wen;
    axi_id_t id;
    logic    lane;
  } trans_t;

endpackage

// File: dv/tb_axi2per.sv
`timescale 1ns/1ps

module tb_axi2per;

  // ****************************************
  // Run length and timing
  // ****************************************

  localparam int unsigned NUM_TRANS   = 400;
  localparam int unsigned CLK_PERIOD  = 20;
  localparam int unsigned DRIVE_DELAY = 2;
  // Byte addresses 0 to 319, the last 16 words lie outside the bank
  localparam int unsigned ADDR_WORDS  = 80;
  // Budget of 40 cycles per transaction
  localparam int unsigned WATCHDOG_NS = NUM_TRANS * 40 * CLK_PERIOD;

  logic                 clk_i = 1'b0;
  logic                 rst_ni;
  logic                 aw_valid_i;
  axi2per_pkg::axi_ax_t aw_i;
  logic                 aw_ready_o;
  logic                 w_valid_i;
  axi2per_pkg::axi_w_t  w_i;
  logic                 w_ready_o;
  logic                 ar_valid_i;
  axi2per_pkg::axi_ax_t ar_i;
  logic                 ar_ready_o;
  logic                 r_valid_o;
  axi2per_pkg::axi_r_t  r_o;
  logic                 r_ready_i;
  logic                 b_valid_o;
  axi2per_pkg::axi_b_t  b_o;
  logic                 b_ready_i;

  // Reference copy of the peripheral memory
  axi2per_pkg::per_data_t model_mem [axi2per_pkg::MEM_WORDS];
  logic [31:0]            rng_state = 32'd83738;
  int unsigned            cycle_cnt = 0;

  axi2per_top UUT (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .aw_valid_i (aw_valid_i),
    .aw_i       (aw_i),
    .aw_ready_o (aw_ready_o),
    .w_valid_i  (w_valid_i),
    .w_i        (w_i),
    .w_ready_o  (w_ready_o),
    .ar_valid_i (ar_valid_i),
    .ar_i       (ar_i),
    .ar_ready_o (ar_ready_o),
    .r_valid_o  (r_valid_o),
    .r_o        (r_o),
    .r_ready_i  (r_ready_i),
    .b_valid_o  (b_valid_o),
    .b_o        (b_o),
    .b_ready_i  (b_ready_i)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // Cycle count, read at the falling edge for latency
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // ****************************************
  // Helpers
  // ****************************************

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Step the generator state
  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic check_value(input string what, input logic [127:0] act,
                             input logic [127:0] exp);
    if (act !== exp) begin
      $display("error at %0t ns: %s, got %0h, expected %0h", $time, what, act, exp);
      $display("tests failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  // Ready is high about three cycles in four
  task automatic drive_readies();
    logic [31:0] r;
    r = next_rand();
    r_ready_i = (r[1:0] != 2'b00);
    b_ready_i = (r[3:2] != 2'b00);
  endtask

  // One transaction, entered and left just after a rising edge
  task automatic run_transaction(input logic is_write, input axi2per_pkg::axi_id_t id,
                                 input axi2per_pkg::axi_addr_t addr,
                                 input axi2per_pkg::axi_data_t data,
                                 input axi2per_pkg::axi_strb_t strb);
    logic                              accepted;
    logic                              done;
    logic                              seen;
    logic                              lane;
    logic                              in_range;
    logic [axi2per_pkg::MEM_IDX_W-1:0] idx;
    axi2per_pkg::per_data_t            word;
    axi2per_pkg::per_be_t              be;
    axi2per_pkg::axi_resp_t            exp_resp;
    axi2per_pkg::axi_data_t            exp_data;
    axi2per_pkg::axi_r_t               r_snap;
    axi2per_pkg::axi_b_t               b_snap;
    int unsigned                       hs_cycle;

    lane     = addr[2];
    in_range = addr < axi2per_pkg::axi_addr_t'(axi2per_pkg::MEM_WORDS * 4);
    idx      = addr[axi2per_pkg::MEM_IDX_W+1:2];
    exp_resp = in_range ? axi2per_pkg::RESP_OKAY : axi2per_pkg::RESP_SLVERR;
    exp_data = '0;
    hs_cycle = 0;

    // Model: half of the AXI word picked by address bit 2
    if (is_write) begin
      word = lane ? data[63:32] : data[31:0];
      be   = lane ? strb[7:4] : strb[3:0];
      if (in_range) begin
        for (int b = 0; b < 4; b++) begin
          if (be[b]) begin
            model_mem[idx][8*b +: 8] = word[8*b +: 8];
          end
        end
      end
    end else if (in_range) begin
      exp_data = lane ? {model_mem[idx], 32'h0} : {32'h0, model_mem[idx]};
    end

    // Address phase, AW and W together
    if (is_write) begin
      aw_i.id    = id;
      aw_i.addr  = addr;
      w_i.data   = data;
      w_i.strb   = strb;
      aw_valid_i = 1'b1;
      w_valid_i  = 1'b1;
    end else begin
      ar_i.id    = id;
      ar_i.addr  = addr;
      ar_valid_i = 1'b1;
    end
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk_i);
      accepted = is_write ? (aw_ready_o & w_ready_o) : ar_ready_o;
      hs_cycle = cycle_cnt;
      @(posedge clk_i);
      #(DRIVE_DELAY);
      drive_readies();
    end
    aw_valid_i = 1'b0;
    w_valid_i  = 1'b0;
    ar_valid_i = 1'b0;

    // Response phase, payload must hold until the handshake
    seen = 1'b0;
    done = 1'b0;
    while (!done) begin
      @(negedge clk_i);
      if (is_write) begin
        check_value("R valid during a write", 128'(r_valid_o), 128'(1'b0));
        if (b_valid_o) begin
          if (!seen) begin
            check_value("B latency", 128'(cycle_cnt - hs_cycle), 128'(32'd3));
            check_value("B id", 128'(b_o.id), 128'(id));
            check_value("B resp", 128'(b_o.resp), 128'(exp_resp));
            b_snap = b_o;
            seen   = 1'b1;
          end
          check_value("B payload held", 128'(b_o), 128'(b_snap));
          done = b_ready_i;
        end
      end else begin
        check_value("B valid during a read", 128'(b_valid_o), 128'(1'b0));
        if (r_valid_o) begin
          if (!seen) begin
            check_value("R latency", 128'(cycle_cnt - hs_cycle), 128'(32'd3));
            check_value("R id", 128'(r_o.id), 128'(id));
            check_value("R data", 128'(r_o.data), 128'(exp_data));
            check_value("R resp", 128'(r_o.resp), 128'(exp_resp));
            check_value("R last", 128'(r_o.last), 128'(1'b1));
            r_snap = r_o;
            seen   = 1'b1;
          end
          check_value("R payload held", 128'(r_o), 128'(r_snap));
          done = r_ready_i;
        end
      end
      @(posedge clk_i);
      #(DRIVE_DELAY);
      drive_readies();
    end
  endtask

  // ****************************************
  // Stimulus
  // ****************************************

  initial begin
    logic [31:0] r_op;
    logic [31:0] r_addr;
    logic [31:0] r_hi;
    logic [31:0] r_lo;

    rst_ni     = 1'b0;
    aw_valid_i = 1'b0;
    aw_i       = '0;
    w_valid_i  = 1'b0;
    w_i        = '0;
    ar_valid_i = 1'b0;
    ar_i       = '0;
    r_ready_i  = 1'b0;
    b_ready_i  = 1'b0;
    foreach (model_mem[i]) begin
      model_mem[i] = '0;
    end

    // Two rising edges under reset
    @(posedge clk_i);
    @(negedge clk_i);
    check_value("ready or valid high in reset",
                128'({aw_ready_o, w_ready_o, ar_ready_o, r_valid_o, b_valid_o}), 128'(5'b0));
    @(posedge clk_i);
    #(DRIVE_DELAY);
    rst_ni = 1'b1;
    drive_readies();

    for (int unsigned n = 0; n < NUM_TRANS; n++) begin
      r_op   = next_rand();
      r_addr = next_rand();
      r_hi   = next_rand();
      r_lo   = next_rand();
      // Bit 0 op, bits 3:1 id, bits 11:4 strobes
      run_transaction(r_op[0], r_op[3:1], (r_addr % ADDR_WORDS) << 2, {r_hi, r_lo},
                      r_op[11:4]);
    end

    $display("all tests passed");
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("tests failed");
    $fatal(1, "watchdog expired, the run did not finish within %0d ns", WATCHDOG_NS);
  end

endmodule

// File: sim.f
common/axi2per_pkg.sv
axi2per/axi2per_req_channel.sv
axi2per/axi2per_res_channel.sv
verilog/per_mem_bank.sv
verilog/axi2per_top.sv
dv/tb_axi2per.sv

// File: verilog/axi2per_top.sv
`timescale 1ns/1ps

module axi2per_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,

  // AXI slave port
  input  logic                 aw_valid_i,
  input  axi2per_pkg::axi_ax_t aw_i,
  output logic                 aw_ready_o,
  input  logic                 w_valid_i,
  input  axi2per_pkg::axi_w_t  w_i,
  output logic                 w_ready_o,
  input  logic                 ar_valid_i,
  input  axi2per_pkg::axi_ax_t ar_i,
  output logic                 ar_ready_o,
  output logic                 r_valid_o,
  output axi2per_pkg::axi_r_t  r_o,
  input  logic                 r_ready_i,
  output logic                 b_valid_o,
  output axi2per_pkg::axi_b_t  b_o,
  input  logic                 b_ready_i
);

  // ****************************************
  // Internal wiring
  // ****************************************

  // Peripheral bus
  logic                   per_req;
  axi2per_pkg::per_req_t  per_req_data;
  logic                   per_gnt;
  logic                   per_r_valid;
  axi2per_pkg::per_resp_t per_resp;

  // Transaction context and completion
  logic                   trans_req;
  axi2per_pkg::trans_t    trans;
  logic                   trans_done;

  // Producer, AXI requests to peripheral requests
  axi2per_req_channel i_req_channel (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .aw_valid_i     (aw_valid_i),
    .aw_i           (aw_i),
    .aw_ready_o     (aw_ready_o),
    .w_valid_i      (w_valid_i),
    .w_i            (w_i),
    .w_ready_o      (w_ready_o),
    .ar_valid_i     (ar_valid_i),
    .ar_i           (ar_i),
    .ar_ready_o     (ar_ready_o),
    .per_req_o      (per_req),
    .per_req_data_o (per_req_data),
    .per_gnt_i      (per_gnt),
    .trans_req_o    (trans_req),
    .trans_o        (trans),
    .trans_done_i   (trans_done)
  );

  // Peripheral target
  per_mem_bank i_mem_bank (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (per_req),
    .req_data_i (per_req_data),
    .gnt_o      (per_gnt),
    .r_valid_o  (per_r_valid),
    .r_resp_o   (per_resp)
  );

  // Consumer, peripheral answers to R and B
  axi2per_res_channel i_res_channel (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .per_r_valid_i (per_r_valid),
    .per_r_resp_i  (per_resp),
    .trans_req_i   (trans_req),
    .trans_i       (trans),
    .r_valid_o     (r_valid_o),
    .r_o           (r_o),
    .r_ready_i     (r_ready_i),
    .b_valid_o     (b_valid_o),
    .b_o           (b_o),
    .b_ready_i     (b_ready_i),
    .trans_done_o  (trans_done)
  );

endmodule

// File: verilog/per_mem_bank.sv
`timescale 1ns/1ps

module per_mem_bank (
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // Request side
  input  logic                   req_i,
  input  axi2per_pkg::per_req_t  req_data_i,
  output logic                   gnt_o,

  // Response one cycle after grant
  output logic                   r_valid_o,
  output axi2per_pkg::per_resp_t r_resp_o
);

  // Word storage
  axi2per_pkg::per_data_t mem_q [axi2per_pkg::MEM_WORDS];

  logic [axi2per_pkg::MEM_IDX_W-1:0] idx;
  logic                              in_range;
  logic                              access;
  logic                              r_valid_q;
  axi2per_pkg::per_resp_t            resp_q;

  // Single target, always ready
  assign gnt_o  = req_i;
  assign access = req_i & gnt_o;

  // Word index from bits 7:2
  assign idx      = req_data_i.add[axi2per_pkg::MEM_IDX_W+1:2];
  // Byte address must fall inside the bank
  assign in_range = req_data_i.add <
                    axi2per_pkg::per_addr_t'(axi2per_pkg::MEM_WORDS * 4);

  // ****************************************
  // Storage and response
  // ****************************************

  always_ff @(posedge clk_i, negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
      for (int unsigned i = 0; i < axi2per_pkg::MEM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else begin
      r_valid_q <= access;
      // Byte-enabled write, dropped when out of range
      if (access && !req_data_i.wen && in_range) begin
        for (int unsigned b = 0; b < 4; b++) begin
          if (req_data_i.be[b]) begin
            mem_q[idx][8*b +: 8] <= req_data_i.wdata[8*b +: 8];
          end
        end
      end
    end
  end

  // Answer payload
  always_ff @(posedge clk_i) begin
    if (access) begin
      resp_q.opc <= ~in_range;
      // Read data only for an in-range read
      if (in_range && req_data_i.wen) begin
        resp_q.rdata <= mem_q[idx];
      end else begin
        resp_q.rdata <= '0;
      end
    end
  end

  assign r_valid_o = r_valid_q;
  assign r_resp_o  = resp_q;

  // ****************************************
  // Checks
  // ****************************************

  // One grant gives a response pulse of exactly one cycle
  assert property (@(posedge clk_i) disable iff (!rst_ni)
      r_valid_o |=> !r_valid_o)
    else $error("Response valid longer than one cycle");

endmodule
